//--- files.f
logic/mon_pkg.sv
logic/apb_if.sv
logic/uart_rx.sv
logic/cmd_decoder.sv
logic/mon_ctrl.sv
logic/data_mem.sv
logic/uart_tx.sv
logic/uart_monitor_top.sv
verif/tb_uart_monitor.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the uart monitor testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_uart_monitor -f files.f \
	-o sim_uart_monitor &&
./obj_dir/sim_uart_monitor | tee /dev/stderr | grep -q -F "TEST PASSED" &&
echo "simulation ok" ||
{ echo "simulation did not pass"; exit 1; }

//--- verif/tb_uart_monitor.sv
// testbench for the uart memory monitor with serial stimulus, dump capture and checks
`timescale 1ns/10ps

module tb_uart_monitor;
	localparam int ADDR_W       = 6;
	localparam int CLKS_PER_BIT = 8;
	localparam int CHARS_SENT   = 216; // all chars driven on rx
	localparam int CHARS_RECV   = 145; // dump chars expected, quit case bounded
	localparam int LIMIT = ((CHARS_SENT + CHARS_RECV) * 10 * CLKS_PER_BIT
		+ (2**ADDR_W) * 4) * 2;

	logic clk;
	logic rst_n;
	logic rx;
	wire  tx;
	wire  busy;

	logic [mon_pkg::DATA_W-1:0] model [2**ADDR_W]; // mirror of data_mem
	logic [7:0] rx_q [$];  // bytes captured from tx
	logic [7:0] exp_q [$]; // expected dump text
	logic [7:0] cap_byte;
	logic cap_active = 1'b0; // receiver inside a frame
	logic first_sent;
	string cur_test;
	int cycle, errors, cap_errs, idle_errs;
	int test_base, n_ok, n_bad, base, n_before, n_after;
	logic [mon_pkg::DATA_W-1:0] w;

	uart_monitor_top #(.ADDR_W(ADDR_W), .CLKS_PER_BIT(CLKS_PER_BIT)) DUT (
		.clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx), .busy(busy)
	);

	always #10 clk = ~clk; // 20 ns period

	// hang guard
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= LIMIT) begin
			$display("timeout after %0d cycles in test %s", cycle, cur_test);
			$display("TEST FAILED");
			$finish;
		end
	end

	// quiet line until the first char goes in
	assert property (@(posedge clk) disable iff (!rst_n) !first_sent |-> (tx && !busy))
		else begin
			idle_errs++;
			$display("tx or busy left idle before any input at cycle %0d", cycle);
		end

	// serial capture of tx, sampled mid bit on the falling edge
	always begin : capture_tx
		@(negedge clk);
		if (rst_n === 1'b1 && tx === 1'b0) begin
			cap_active = 1'b1;
			repeat (CLKS_PER_BIT / 2) @(negedge clk); // mid start bit
			repeat (8) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				cap_byte = {tx, cap_byte[7:1]}; // lsb first
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (tx === 1'b1)
				else begin
					cap_errs++;
					$display("stop bit low on tx in test %s", cur_test);
				end
			rx_q.push_back(cap_byte);
			cap_active = 1'b0;
		end
	end

	// lower case hex text
	function automatic logic [7:0] hex_char(input logic [3:0] n);
		string digits;
		digits = "0123456789abcdef";
		return digits[n];
	endfunction

	function automatic int total_errs();
		return errors + cap_errs + idle_errs;
	endfunction

	task automatic send_char(input logic [7:0] c);
		logic [7:0] sh;
		sh = c;
		first_sent = 1'b1;
		@(negedge clk);
		rx = 1'b0; // start bit
		repeat (CLKS_PER_BIT) @(negedge clk);
		repeat (8) begin
			rx = sh[0];
			sh = sh >> 1;
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		rx = 1'b1; // stop bit
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic send_word(input logic [mon_pkg::DATA_W-1:0] val);
		logic [mon_pkg::DATA_W-1:0] sh;
		sh = val;
		repeat (mon_pkg::HEX_DIGITS) begin
			send_char(hex_char(sh[31:28])); // msb nibble first
			sh = sh << 4;
		end
	endtask

	task automatic send_str(input string s);
		for (int i = 0; i < s.len(); i++)
			send_char(s[i]);
	endtask

	task automatic dump_cmd(input logic [31:0] first, input logic [31:0] last);
		send_char(mon_pkg::CH_R);
		send_word(first);
		send_word(last);
	endtask

	// text the dump must produce, stops once addr reaches last
	task automatic build_dump(input int first, input int last);
		int a;
		logic done;
		logic [mon_pkg::DATA_W-1:0] sh;
		exp_q.delete();
		a = first;
		done = 1'b0;
		while (!done) begin
			sh = model[a[ADDR_W-1:0]];
			repeat (mon_pkg::HEX_DIGITS) begin
				exp_q.push_back(hex_char(sh[31:28]));
				sh = sh << 4;
			end
			exp_q.push_back(mon_pkg::CH_CR);
			exp_q.push_back(mon_pkg::CH_LF);
			done = (a >= last);
			a++;
		end
	endtask

	// busy low and tx idle for a whole frame
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (busy !== 1'b0) @(negedge clk);
		while (quiet < 10 * CLKS_PER_BIT) begin
			@(negedge clk);
			quiet = (cap_active || !tx) ? 0 : quiet + 1;
		end
	endtask

	task automatic compare_char(input int i);
		assert (rx_q[base + i] === exp_q[i])
			else begin
				errors++;
				$display("Mismatch %s char %0d expected 0x%02h actual 0x%02h",
					cur_test, i, exp_q[i], rx_q[base + i]);
			end
	endtask

	task automatic check_dump();
		int got;
		while (rx_q.size() - base < exp_q.size()) @(negedge clk);
		wait_quiet(); // catch any extra chars
		got = rx_q.size() - base;
		assert (got == exp_q.size())
			else begin
				errors++;
				$display("Mismatch %s char count expected %0d actual %0d",
					cur_test, exp_q.size(), got);
			end
		for (int i = 0; i < got && i < exp_q.size(); i++)
			compare_char(i);
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_base = total_errs();
		base      = rx_q.size();
	endtask

	task automatic end_test();
		int n;
		n = total_errs() - test_base;
		if (n == 0) begin
			n_ok++;
			$display("test %s ok", cur_test);
		end else begin
			n_bad++;
			$display("test %s had %0d errors", cur_test, n);
		end
	endtask

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		rx         = 1'b1; // line idle
		first_sent = 1'b0;
		void'($urandom(68));
		model      = '{default: '0}; // memory resets to zero
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		begin_test("reset_idle");
		repeat (20) begin
			@(negedge clk);
			assert (tx === 1'b1 && busy === 1'b0)
				else begin
					errors++;
					$display("Mismatch %s expected tx 1 busy 0 actual tx %b busy %b",
						cur_test, tx, busy);
				end
		end
		end_test();

		begin_test("write_read");
		send_char(mon_pkg::CH_W);
		send_word(32'd5);
		for (int i = 0; i < 4; i++) begin
			w = $urandom();
			model[ADDR_W'(5 + i)] = w;
			send_word(w);
		end
		send_char(mon_pkg::CH_Q);
		build_dump(5, 8);
		dump_cmd(32'd5, 32'd8);
		check_dump();
		end_test();

		begin_test("clear");
		send_char(mon_pkg::CH_T);
		while (busy !== 1'b1) @(negedge clk);
		while (busy !== 1'b0) @(negedge clk);
		model = '{default: '0};
		build_dump(5, 8);
		dump_cmd(32'd5, 32'd8);
		check_dump();
		end_test();

		begin_test("quit_partial");
		send_char(mon_pkg::CH_W);
		send_word(32'd9);
		for (int i = 0; i < 2; i++) begin
			w = $urandom();
			model[ADDR_W'(9 + i)] = w;
			send_word(w);
		end
		send_char(mon_pkg::CH_Q);
		send_char(mon_pkg::CH_W);
		send_word(32'd10);
		send_str("1a2b3"); // five digits, then dropped
		send_char(mon_pkg::CH_Q);
		build_dump(9, 10);
		dump_cmd(32'd9, 32'd10);
		check_dump();
		end_test();

		begin_test("junk_chars");
		send_char(mon_pkg::CH_CR); // no effect in idle
		send_char(mon_pkg::CH_W);
		send_str("000,000.1-4");     // address 0x14
		send_str("Xde!ad:BEbe_efZ"); // only lower case hex counts
		send_char(mon_pkg::CH_Q);
		model[ADDR_W'(20)] = 32'hdeadbeef;
		build_dump(20, 20);
		dump_cmd(32'd20, 32'd20);
		check_dump();
		end_test();

		begin_test("end_below_start");
		build_dump(20, 9); // start word alone
		dump_cmd(32'd20, 32'd9);
		check_dump();
		end_test();

		begin_test("quit_dump");
		build_dump(0, 2**ADDR_W - 1);
		dump_cmd(32'd0, 32'(2**ADDR_W - 1));
		while (rx_q.size() - base < 15) @(negedge clk); // into the second line
		n_before = rx_q.size() - base;
		send_char(mon_pkg::CH_Q);
		wait_quiet();
		n_after = rx_q.size() - base;
		assert (n_after - n_before <= 10)
			else begin
				errors++;
				$display("Mismatch %s chars after q expected at most 10 actual %0d",
					cur_test, n_after - n_before);
			end
		assert (n_after < exp_q.size())
			else begin
				errors++;
				$display("dump in %s ran to the last word although q was sent", cur_test);
			end
		for (int i = 0; i < n_after && i < exp_q.size(); i++)
			compare_char(i);
		end_test();

		$display("summary %0d tests clean, %0d tests with errors", n_ok, n_bad);
		if (n_bad == 0 && total_errs() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- logic/uart_monitor_top.sv
// uart memory monitor top, receiver through memory to transmitter
`timescale 1ns/10ps

module uart_monitor_top #(
	parameter int ADDR_W       = 6, // 64 words
	parameter int CLKS_PER_BIT = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic rx,
	output logic tx,
	output logic busy
);
	logic [7:0] rx_byte;
	logic       byte_valid;
	logic [7:0] tx_byte;
	logic       tx_start;
	logic       tx_busy;

	apb_if #(.ADDR_W(ADDR_W)) apb ();
	mon_cmd_if cmd_bus ();

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.clk(clk), .rst_n(rst_n), .rx(rx), .rx_byte(rx_byte), .byte_valid(byte_valid)
	);

	cmd_decoder u_dec (
		.clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .byte_valid(byte_valid), .cmd(cmd_bus)
	);

	mon_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
		.clk(clk), .rst_n(rst_n), .cmd(cmd_bus), .apb(apb),
		.tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy)
	);

	data_mem #(.ADDR_W(ADDR_W)) u_mem (.clk(clk), .rst_n(rst_n), .apb(apb));

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.clk(clk), .rst_n(rst_n), .tx_byte(tx_byte), .tx_start(tx_start),
		.tx(tx), .tx_busy(tx_busy)
	);

	assign busy = cmd_bus.running; // dump or clear in progress

endmodule

//--- logic/uart_tx.sv
// uart transmitter, 8n1 frame with busy flag
`timescale 1ns/10ps

module uart_tx #(parameter int CLKS_PER_BIT = 8) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx,
	output logic       tx_busy
);
	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

	logic          active;
	logic [9:0]    frame;   // stop, data, start
	logic [CW-1:0] baud;
	logic [3:0]    bit_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			frame   <= '1;
			baud    <= '0;
			bit_cnt <= 4'd0;
		end else if (!active) begin
			baud    <= '0;
			bit_cnt <= 4'd0;
			if (tx_start) begin
				frame  <= {1'b1, tx_byte, 1'b0};
				active <= 1'b1;
			end
		end else if (baud == FULL_BIT) begin
			baud  <= '0;
			frame <= {1'b1, frame[9:1]}; // lsb first
			if (bit_cnt == 4'd9)
				active <= 1'b0; // end of stop bit
			else
				bit_cnt <= bit_cnt + 4'd1;
		end else begin
			baud <= baud + 1'b1;
		end
	end

	assign tx      = active ? frame[0] : 1'b1; // idle high
	assign tx_busy = active || tx_start;       // busy from the start strobe on

endmodule

//--- logic/data_mem.sv
// apb slave word memory, zero write wait, one read wait state
`timescale 1ns/10ps

module data_mem #(parameter int ADDR_W = 6) (
	input  logic clk,
	input  logic rst_n,
	apb_if.slave apb
);
	localparam int DEPTH = 2**ADDR_W;

	logic [mon_pkg::DATA_W-1:0] mem [DEPTH];
	logic wr_acc, rd_acc;
	logic rd_ready; // second read access cycle

	assign wr_acc = apb.psel && apb.penable && apb.pwrite;
	assign rd_acc = apb.psel && apb.penable && !apb.pwrite;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
			rd_ready <= 1'b0;
		end else begin
			if (wr_acc)
				mem[apb.paddr] <= apb.pwdata; // done in first access cycle
			rd_ready <= rd_acc && !rd_ready;
		end
	end

	// read data lands one cycle after the first access cycle
	always_ff @(posedge clk) begin
		if (rd_acc && !rd_ready)
			apb.prdata <= mem[apb.paddr];
	end

	assign apb.pready = wr_acc || rd_ready;

endmodule

//--- logic/mon_ctrl.sv
// monitor controller running writes, dumps and clears as apb transfers
`timescale 1ns/10ps

module mon_ctrl #(parameter int ADDR_W = 6) (
	input  logic       clk,
	input  logic       rst_n,
	mon_cmd_if.ctrl    cmd,
	apb_if.master      apb,
	output logic [7:0] tx_byte,
	output logic       tx_start,
	input  logic       tx_busy
);
	localparam int NW = $clog2(mon_pkg::HEX_DIGITS);
	localparam logic [NW-1:0] LAST_NIB = NW'(mon_pkg::HEX_DIGITS - 1);

	typedef enum logic [2:0] {
		S_IDLE, S_WSETUP, S_WACC, S_RSETUP, S_RACC, S_HEX, S_CR, S_LF
	} ctrl_state_t;

	ctrl_state_t state;
	logic [ADDR_W-1:0] ptr;      // write pointer, dump and clear address
	logic [ADDR_W-1:0] end_addr;
	logic [NW-1:0]     nib_cnt;
	logic [mon_pkg::DATA_W-1:0] wdata;
	logic [mon_pkg::DATA_W-1:0] rd_word; // shifts out msb nibble first
	logic [7:0] next_char;
	logic running; // dump or clear in progress
	logic quit_pend, stop_req, dumping, send;

	assign dumping  = state inside {S_RSETUP, S_RACC, S_HEX, S_CR, S_LF};
	assign stop_req = quit_pend || cmd.quit;
	assign send     = (state inside {S_HEX, S_CR, S_LF}) && !tx_busy && !stop_req;

	always_comb begin
		case (state)
			S_HEX:   next_char = mon_pkg::nibble_to_ascii(rd_word[mon_pkg::DATA_W-1 -: 4]);
			S_CR:    next_char = mon_pkg::CH_CR;
			default: next_char = mon_pkg::CH_LF;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			ptr       <= '0;
			end_addr  <= '0;
			nib_cnt   <= '0;
			running   <= 1'b0;
			quit_pend <= 1'b0;
			tx_start  <= 1'b0;
		end else begin
			tx_start <= send;
			if (cmd.quit && dumping)
				quit_pend <= 1'b1; // honoured at the next char boundary
			case (state)
				S_IDLE:
					if (cmd.addr_set || cmd.start_set)
						ptr <= cmd.word[ADDR_W-1:0];
					else if (cmd.data_set)
						state <= S_WSETUP;
					else if (cmd.end_set) begin
						end_addr <= cmd.word[ADDR_W-1:0];
						running  <= 1'b1;
						state    <= S_RSETUP;
					end else if (cmd.clear_start) begin
						ptr     <= '0;
						running <= 1'b1;
						state   <= S_WSETUP;
					end
				S_WSETUP: state <= S_WACC;
				S_WACC: if (apb.pready) begin
					ptr <= ptr + 1'b1;
					if (running && ptr != '1)
						state <= S_WSETUP; // next clear word
					else begin
						running <= 1'b0;
						state   <= S_IDLE;
					end
				end
				S_RSETUP: state <= S_RACC;
				S_RACC: if (apb.pready) begin
					nib_cnt <= '0;
					state   <= S_HEX;
				end
				S_HEX: if (send) begin
					nib_cnt <= nib_cnt + 1'b1;
					if (nib_cnt == LAST_NIB)
						state <= S_CR;
				end
				S_CR: if (send) state <= S_LF;
				S_LF: if (send) begin
					if (ptr >= end_addr) begin // end below start stops after one word
						running <= 1'b0;
						state   <= S_IDLE;
					end else begin
						ptr   <= ptr + 1'b1;
						state <= S_RSETUP;
					end
				end
				default: state <= S_IDLE;
			endcase
			// quit leaves the dump once no transfer is open
			if (stop_req && (state inside {S_HEX, S_CR, S_LF}
				|| (state == S_RACC && apb.pready))) begin
				running   <= 1'b0;
				quit_pend <= 1'b0;
				state     <= S_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && cmd.data_set)
			wdata <= cmd.word;
		else if (state == S_IDLE && cmd.clear_start)
			wdata <= '0;
		if (state == S_RACC && apb.pready)
			rd_word <= apb.prdata;
		else if (send && state == S_HEX)
			rd_word <= {rd_word[mon_pkg::DATA_W-5:0], 4'h0};
		if (send)
			tx_byte <= next_char;
	end

	assign cmd.running = running;
	assign apb.psel    = state inside {S_WSETUP, S_WACC, S_RSETUP, S_RACC};
	assign apb.penable = state inside {S_WACC, S_RACC};
	assign apb.pwrite  = state inside {S_WSETUP, S_WACC};
	assign apb.paddr   = ptr;
	assign apb.pwdata  = wdata;

endmodule

//--- logic/cmd_decoder.sv
// command character classifier, command state machine and hex word assembler
`timescale 1ns/10ps

module cmd_decoder (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] rx_byte,
	input  logic       byte_valid,
	mon_cmd_if.decoder cmd
);
	localparam int CNT_W = $clog2(mon_pkg::HEX_DIGITS);
	localparam logic [CNT_W-1:0] LAST_DIGIT = CNT_W'(mon_pkg::HEX_DIGITS - 1);

	logic [7:0] pdata;       // registered rx byte
	logic       data_en;
	logic [4:0] hex_dec;
	logic       num_char;
	logic [3:0] half_data;
	logic       cmd_q, cmd_w, cmd_r, cmd_t;
	mon_pkg::cmd_state_t state, next_state;
	logic       bin_data_set, word_start;
	logic       word_valid_pre, word_valid;
	logic [CNT_W-1:0] data_cntr;
	logic [mon_pkg::DATA_W-1:0] data_word;     // partial word
	logic [mon_pkg::DATA_W-1:0] data_word_out; // completed word

	always_ff @(posedge clk) begin
		if (byte_valid)
			pdata <= rx_byte;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			data_en <= 1'b0;
		else
			data_en <= byte_valid; // one cycle behind the rx strobe
	end

	// classify
	assign hex_dec   = mon_pkg::ascii_to_nibble(pdata);
	assign num_char  = hex_dec[4];
	assign half_data = hex_dec[3:0];
	assign cmd_q = data_en && (pdata == mon_pkg::CH_Q);
	assign cmd_w = data_en && (pdata == mon_pkg::CH_W);
	assign cmd_r = data_en && (pdata == mon_pkg::CH_R);
	assign cmd_t = data_en && (pdata == mon_pkg::CH_T);
	// CR, upper case, punctuation fall through untouched

	always_comb begin
		next_state = state;
		case (state)
			mon_pkg::IDLE: if (!cmd.running) begin // controller still draining after q
				if (cmd_w)
					next_state = mon_pkg::W_ADDR;
				else if (cmd_r)
					next_state = mon_pkg::R_START;
				else if (cmd_t)
					next_state = mon_pkg::CLEAR;
			end
			mon_pkg::W_ADDR:
				if (cmd_q)
					next_state = mon_pkg::IDLE;
				else if (word_valid)
					next_state = mon_pkg::W_DATA;
			mon_pkg::W_DATA: if (cmd_q) next_state = mon_pkg::IDLE; // data until q
			mon_pkg::R_START:
				if (cmd_q)
					next_state = mon_pkg::IDLE;
				else if (word_valid)
					next_state = mon_pkg::R_END;
			mon_pkg::R_END:
				if (cmd_q)
					next_state = mon_pkg::IDLE;
				else if (word_valid)
					next_state = mon_pkg::R_DUMP;
			mon_pkg::R_DUMP: if (cmd_q || !cmd.running) next_state = mon_pkg::IDLE;
			mon_pkg::CLEAR: if (!cmd.running) next_state = mon_pkg::IDLE; // q ignored here
			default: next_state = mon_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= mon_pkg::IDLE;
		else
			state <= next_state;
	end

	// hex word assembly
	assign bin_data_set = data_en && num_char && (state inside {mon_pkg::W_ADDR,
		mon_pkg::W_DATA, mon_pkg::R_START, mon_pkg::R_END});
	assign word_start     = (state == mon_pkg::IDLE) && (next_state != mon_pkg::IDLE);
	assign word_valid_pre = bin_data_set && (data_cntr == LAST_DIGIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_word  <= '0;
			data_cntr  <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= word_valid_pre;
			if (cmd_q || word_start) begin
				data_word <= '0;
				data_cntr <= '0;
			end else if (bin_data_set) begin
				data_word <= {data_word[mon_pkg::DATA_W-5:0], half_data};
				data_cntr <= (data_cntr == LAST_DIGIT) ? '0 : data_cntr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (word_valid_pre)
			data_word_out <= {data_word[mon_pkg::DATA_W-5:0], half_data};
	end

	// strobes to the controller
	assign cmd.word        = data_word_out;
	assign cmd.addr_set    = (state == mon_pkg::W_ADDR) && word_valid;
	assign cmd.data_set    = (state == mon_pkg::W_DATA) && word_valid;
	assign cmd.start_set   = (state == mon_pkg::R_START) && word_valid;
	assign cmd.end_set     = (state == mon_pkg::R_END) && word_valid;
	assign cmd.clear_start = (state == mon_pkg::IDLE) && (next_state == mon_pkg::CLEAR);
	assign cmd.quit        = cmd_q;

endmodule

//--- logic/uart_rx.sv
// uart receiver with two-flop sync, mid-bit sampling and stop bit check
`timescale 1ns/10ps

module uart_rx #(parameter int CLKS_PER_BIT = 8) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       byte_valid
);
	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta, rx_s;   // synchronizer
	logic [CW-1:0] cnt;    // baud counter
	logic [2:0] bit_idx;
	logic sample_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1; // line idles high
			rx_s    <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_s    <= rx_meta;
		end
	end

	assign sample_data = (state == RX_DATA) && (cnt == FULL_BIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= RX_IDLE;
			cnt        <= '0;
			bit_idx    <= 3'd0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			cnt        <= cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rx_s)
						state <= RX_START; // falling edge of start bit
				end
				RX_START: if (cnt == HALF_BIT) begin
					cnt   <= '0;
					state <= rx_s ? RX_IDLE : RX_DATA; // glitch check at mid start
				end
				RX_DATA: if (sample_data) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (cnt == FULL_BIT) begin
					byte_valid <= rx_s; // bad stop bit drops the frame
					state      <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (sample_data)
			rx_byte <= {rx_s, rx_byte[7:1]};
	end

endmodule

//--- logic/apb_if.sv
// apb bus interface and decoder-to-controller command interface
`timescale 1ns/10ps

interface apb_if #(parameter int ADDR_W = 6);
	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	logic [ADDR_W-1:0]          paddr;   // word address
	logic [mon_pkg::DATA_W-1:0] pwdata;
	logic [mon_pkg::DATA_W-1:0] prdata;
	logic                       pready;

	modport master (output psel, penable, pwrite, paddr, pwdata, input prdata, pready);
	modport slave  (input psel, penable, pwrite, paddr, pwdata, output prdata, pready);
endinterface

interface mon_cmd_if;
	logic [mon_pkg::DATA_W-1:0] word; // assembled hex value
	logic addr_set;    // w start address
	logic data_set;    // w data word
	logic start_set;   // r start address
	logic end_set;     // r end address, kicks off dump
	logic clear_start;
	logic quit;
	logic running;     // dump or clear busy

	modport decoder (output word, addr_set, data_set, start_set, end_set, clear_start, quit,
		input running);
	modport ctrl (input word, addr_set, data_set, start_set, end_set, clear_start, quit,
		output running);
endinterface

//--- logic/mon_pkg.sv
// monitor widths, ascii codes, decoder state type, hex/ascii conversion functions
package mon_pkg;

	localparam int DATA_W     = 32; // memory word width
	localparam int HEX_DIGITS = 8;  // hex chars per word

	// ascii codes seen on the serial line
	localparam logic [7:0] CH_CR = 8'h0d;
	localparam logic [7:0] CH_LF = 8'h0a;
	localparam logic [7:0] CH_Q  = 8'h71; // quit
	localparam logic [7:0] CH_W  = 8'h77; // write words
	localparam logic [7:0] CH_R  = 8'h72; // read and dump
	localparam logic [7:0] CH_T  = 8'h74; // clear memory

	typedef enum logic [2:0] {
		IDLE,
		W_ADDR,  // w, collecting start address
		W_DATA,  // w, collecting data words
		R_START,
		R_END,
		R_DUMP,  // waiting on controller
		CLEAR    // waiting on controller
	} cmd_state_t;

	// 0..9 -> '0'..'9', 10..15 -> 'a'..'f'
	function automatic logic [7:0] nibble_to_ascii(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		else
			return 8'h57 + {4'h0, nib}; // 'a' minus ten
	endfunction

	// {is_hex, value}, lower case only
	function automatic logic [4:0] ascii_to_nibble(input logic [7:0] ch);
		logic [4:0] res;
		res = 5'h00;
		if (ch >= 8'h30 && ch <= 8'h39)
			res = {1'b1, ch[3:0]};
		else if (ch >= 8'h61 && ch <= 8'h66)
			res = {1'b1, ch[3:0] + 4'd9}; // 'a' has low nibble 1
		return res;
	endfunction

endpackage
